/* filelist.f */
hw/rp_pkg.sv
hw/apb_region_decoder.sv
hw/hk_regs.sv
hw/adc_frontend.sv
hw/p_ctrl.sv
hw/dac_backend.sv
hw/rp_top.sv
verification/rp_props.sv
verification/rp_tb.sv

/* hw/adc_frontend.sv */
// ADC input stage, pin words to signed samples with digital loopback
`timescale 1ns/1ps
`default_nettype none

module adc_frontend (
  input  wire                    adc_clk,
  input  wire                    rst_n_i,
  input  wire rp_pkg::adc_pins_t adc_dat_i,     // Raw pins, negative slope
  input  wire                    digital_loop_i,
  input  wire rp_pkg::smp_pair_t dac_smp_i,     // Output samples for loopback
  output rp_pkg::smp_pair_t      adc_smp_o
);

  import rp_pkg::*;

  // Drop the two spare LSBs, keep MSB, flip the rest
  function automatic sample_t pin_to_smp(input logic [adc_pin_w-1:0] pin);
    logic [smp_w-1:0] raw;
    raw = pin[adc_pin_w-1:adc_pin_w-smp_w];
    return {raw[smp_w-1], ~raw[smp_w-2:0]};
  endfunction

  // Input register, one cycle
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      adc_smp_o <= '0;
    end else if (digital_loop_i) begin
      adc_smp_o <= dac_smp_i;                    // DAC stands in for ADC
    end else begin
      adc_smp_o.a <= pin_to_smp(adc_dat_i.a);
      adc_smp_o.b <= pin_to_smp(adc_dat_i.b);
    end
  end

endmodule

`default_nettype wire

/* hw/apb_region_decoder.sv */
// APB region decoder, fans the request out to three slaves and returns one response
`timescale 1ns/1ps
`default_nettype none

module apb_region_decoder (
  input  wire                   adc_clk,
  input  wire                   rst_n_i,
  input  wire rp_pkg::apb_req_t m_req_i,               // From the master
  output rp_pkg::apb_rsp_t      m_rsp_o,
  output rp_pkg::apb_req_t      s_req_o [rp_pkg::n_slv],
  input  wire rp_pkg::apb_rsp_t s_rsp_i [rp_pkg::n_slv]
);

  import rp_pkg::*;

  logic [1:0] rgn;   // Region of current address
  logic       acc;   // Access phase

  assign rgn = m_req_i.paddr[apb_aw-1:region_lsb];
  assign acc = m_req_i.psel & m_req_i.penable;

  ////////////////////////////////////////////////////////////
  // Request fan-out
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < n_slv; i++) begin
      s_req_o[i]      = m_req_i;
      s_req_o[i].psel = m_req_i.psel & (rgn == 2'(i));  // Only one slave sees psel
    end
  end

  ////////////////////////////////////////////////////////////
  // Response return
  ////////////////////////////////////////////////////////////

  always_comb begin
    m_rsp_o = '0;
    if (rgn < 2'(n_slv)) begin
      m_rsp_o = s_rsp_i[rgn];
    end else begin
      // Unmapped hole, answer with an error
      m_rsp_o.prdata  = '0;
      m_rsp_o.pready  = acc;
      m_rsp_o.pslverr = acc;
    end
  end

endmodule

`default_nettype wire

/* hw/dac_backend.sv */
// DAC output stage, adds DC offset, saturates and forms negative-slope codes
`timescale 1ns/1ps
`default_nettype none

module dac_backend (
  input  wire                    adc_clk,
  input  wire                    rst_n_i,
  input  wire rp_pkg::apb_req_t  req_i,
  output rp_pkg::apb_rsp_t       rsp_o,
  input  wire rp_pkg::smp_pair_t pid_smp_i,
  output rp_pkg::smp_pair_t      dac_smp_o,    // Saturated, back to loopback
  output rp_pkg::dac_code_t      dac_a_o,
  output rp_pkg::dac_code_t      dac_b_o
);

  import rp_pkg::*;

  logic [region_lsb-1:0] addr;
  logic                  wr_en;
  sample_t               ofs_a;   // DC offsets
  sample_t               ofs_b;
  logic signed [smp_w:0] sum_a;   // One guard bit
  logic signed [smp_w:0] sum_b;
  sample_t               sat_a;
  sample_t               sat_b;

  assign addr  = req_i.paddr[region_lsb-1:0];
  assign wr_en = req_i.psel & req_i.penable & req_i.pwrite;

  // Overflow when the two top bits differ
  function automatic sample_t sat_sum(input logic signed [smp_w:0] s);
    if (s[smp_w] != s[smp_w-1]) begin
      return {s[smp_w], {(smp_w-1){~s[smp_w]}}};
    end
    return s[smp_w-1:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // Offset registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      ofs_a <= '0;
      ofs_b <= '0;
    end else if (wr_en) begin
      case (addr)
        reg_ofs_a: ofs_a <= req_i.pwdata[smp_w-1:0];
        reg_ofs_b: ofs_b <= req_i.pwdata[smp_w-1:0];
        default:   ;
      endcase
    end
  end

  always_comb begin
    rsp_o.pready  = req_i.psel & req_i.penable;
    rsp_o.pslverr = 1'b0;
    case (addr)
      reg_ofs_a: rsp_o.prdata = {{(32-smp_w){ofs_a[smp_w-1]}}, ofs_a};
      reg_ofs_b: rsp_o.prdata = {{(32-smp_w){ofs_b[smp_w-1]}}, ofs_b};
      default:   rsp_o.prdata = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Sum, clamp, output registers
  ////////////////////////////////////////////////////////////

  assign sum_a = {pid_smp_i.a[smp_w-1], pid_smp_i.a} + {ofs_a[smp_w-1], ofs_a};
  assign sum_b = {pid_smp_i.b[smp_w-1], pid_smp_i.b} + {ofs_b[smp_w-1], ofs_b};
  assign sat_a = sat_sum(sum_a);
  assign sat_b = sat_sum(sum_b);

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      dac_smp_o <= '0;
      dac_a_o   <= 14'h1fff;                     // Code of signed zero
      dac_b_o   <= 14'h1fff;
    end else begin
      dac_smp_o.a <= sat_a;
      dac_smp_o.b <= sat_b;
      dac_a_o     <= {sat_a[smp_w-1], ~sat_a[smp_w-2:0]};  // Negative slope
      dac_b_o     <= {sat_b[smp_w-1], ~sat_b[smp_w-2:0]};
    end
  end

endmodule

`default_nettype wire

/* hw/hk_regs.sv */
// Housekeeping registers with design ID, loopback switch, LEDs and ADC readback
`timescale 1ns/1ps
`default_nettype none

module hk_regs (
  input  wire                    adc_clk,
  input  wire                    rst_n_i,
  input  wire rp_pkg::apb_req_t  req_i,
  output rp_pkg::apb_rsp_t       rsp_o,
  input  wire rp_pkg::smp_pair_t adc_smp_i,       // Live samples for readback
  output logic                   digital_loop_o,
  output logic [7:0]             led_o
);

  import rp_pkg::*;

  logic [region_lsb-1:0] addr;   // Offset inside region
  logic                  wr_en;

  assign addr  = req_i.paddr[region_lsb-1:0];
  assign wr_en = req_i.psel & req_i.penable & req_i.pwrite;

  ////////////////////////////////////////////////////////////
  // Writable registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
    end else if (wr_en) begin
      case (addr)
        reg_ctrl: digital_loop_o <= req_i.pwdata[0];
        reg_led:  led_o          <= req_i.pwdata[7:0];
        default:  ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    rsp_o.pready  = req_i.psel & req_i.penable;  // No wait states
    rsp_o.pslverr = 1'b0;
    case (addr)
      reg_id:    rsp_o.prdata = design_id;
      reg_ctrl:  rsp_o.prdata = {31'd0, digital_loop_o};
      reg_led:   rsp_o.prdata = {24'd0, led_o};
      // Samples come back sign extended
      reg_adc_a: rsp_o.prdata = {{(32-smp_w){adc_smp_i.a[smp_w-1]}}, adc_smp_i.a};
      reg_adc_b: rsp_o.prdata = {{(32-smp_w){adc_smp_i.b[smp_w-1]}}, adc_smp_i.b};
      default:   rsp_o.prdata = '0;   // Unknown offset reads 0
    endcase
  end

endmodule

`default_nettype wire

/* hw/p_ctrl.sv */
// Two-channel proportional controller with setpoint and gain registers on APB
`timescale 1ns/1ps
`default_nettype none

module p_ctrl (
  input  wire                    adc_clk,
  input  wire                    rst_n_i,
  input  wire rp_pkg::apb_req_t  req_i,
  output rp_pkg::apb_rsp_t       rsp_o,
  input  wire rp_pkg::smp_pair_t adc_smp_i,
  output rp_pkg::smp_pair_t      pid_smp_o
);

  import rp_pkg::*;

  logic [region_lsb-1:0]    addr;
  logic                     wr_en;
  sample_t                  sp_a;     // Setpoints
  sample_t                  sp_b;
  logic signed [kp_w-1:0]   kp_a;     // Gains, Q3.8
  logic signed [kp_w-1:0]   kp_b;
  logic signed [err_w-1:0]  err_a;    // Stage 1
  logic signed [err_w-1:0]  err_b;
  logic signed [prod_w-1:0] prod_a;
  logic signed [prod_w-1:0] prod_b;
  logic signed [shr_w-1:0]  shr_a;    // Fraction bits dropped
  logic signed [shr_w-1:0]  shr_b;

  assign addr  = req_i.paddr[region_lsb-1:0];
  assign wr_en = req_i.psel & req_i.penable & req_i.pwrite;

  // Clamp to 14 bit signed, top bits must all match the sign
  function automatic sample_t sat_smp(input logic signed [shr_w-1:0] v);
    logic [shr_w-smp_w:0] top;
    top = v[shr_w-1:smp_w-1];
    if (&top || !(|top)) begin
      return v[smp_w-1:0];
    end
    return {v[shr_w-1], {(smp_w-1){~v[shr_w-1]}}};
  endfunction

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      sp_a <= '0;
      sp_b <= '0;
      kp_a <= '0;
      kp_b <= '0;
    end else if (wr_en) begin
      case (addr)
        reg_sp_a: sp_a <= req_i.pwdata[smp_w-1:0];
        reg_kp_a: kp_a <= req_i.pwdata[kp_w-1:0];
        reg_sp_b: sp_b <= req_i.pwdata[smp_w-1:0];
        reg_kp_b: kp_b <= req_i.pwdata[kp_w-1:0];
        default:  ;
      endcase
    end
  end

  always_comb begin
    rsp_o.pready  = req_i.psel & req_i.penable;
    rsp_o.pslverr = 1'b0;
    case (addr)
      reg_sp_a: rsp_o.prdata = {{(32-smp_w){sp_a[smp_w-1]}}, sp_a};
      reg_kp_a: rsp_o.prdata = {{(32-kp_w){kp_a[kp_w-1]}}, kp_a};
      reg_sp_b: rsp_o.prdata = {{(32-smp_w){sp_b[smp_w-1]}}, sp_b};
      reg_kp_b: rsp_o.prdata = {{(32-kp_w){kp_b[kp_w-1]}}, kp_b};
      default:  rsp_o.prdata = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Datapath, error then scaled product
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    err_a <= {sp_a[smp_w-1], sp_a} - {adc_smp_i.a[smp_w-1], adc_smp_i.a};
    err_b <= {sp_b[smp_w-1], sp_b} - {adc_smp_i.b[smp_w-1], adc_smp_i.b};
  end

  assign prod_a = err_a * kp_a;                 // Signed multiply
  assign prod_b = err_b * kp_b;
  assign shr_a  = prod_a[prod_w-1:kp_shift];    // Arithmetic shift by slicing
  assign shr_b  = prod_b[prod_w-1:kp_shift];

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      pid_smp_o <= '0;
    end else begin
      pid_smp_o.a <= sat_smp(shr_a);
      pid_smp_o.b <= sat_smp(shr_b);
    end
  end

endmodule

`default_nettype wire

/* hw/rp_pkg.sv */
// Shared widths, register map and bus types of the two-channel analog path
`default_nettype none

package rp_pkg;

  ////////////////////////////////////////////////////////////
  // Sample path widths
  ////////////////////////////////////////////////////////////

  localparam int adc_pin_w = 16;              // Raw pin word, bits 1:0 unused
  localparam int smp_w     = 14;
  localparam int kp_w      = 12;              // Signed gain
  localparam int kp_shift  = 8;               // Gain fraction bits
  localparam int err_w     = smp_w + 1;       // Setpoint minus sample
  localparam int prod_w    = err_w + kp_w;    // Full product
  localparam int shr_w     = prod_w - kp_shift;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////

  localparam int apb_aw     = 12;
  localparam int region_lsb = 10;             // paddr[11:10] picks the region
  localparam int n_slv      = 3;              // Mapped regions, 3 is a hole

  localparam logic [1:0] rgn_hk  = 2'd0;
  localparam logic [1:0] rgn_pid = 2'd1;
  localparam logic [1:0] rgn_dac = 2'd2;

  // Housekeeping
  localparam logic [region_lsb-1:0] reg_id    = 10'h000;
  localparam logic [region_lsb-1:0] reg_ctrl  = 10'h004;  // Bit 0 digital loop
  localparam logic [region_lsb-1:0] reg_led   = 10'h008;
  localparam logic [region_lsb-1:0] reg_adc_a = 10'h00c;
  localparam logic [region_lsb-1:0] reg_adc_b = 10'h010;
  // Controller
  localparam logic [region_lsb-1:0] reg_sp_a  = 10'h000;
  localparam logic [region_lsb-1:0] reg_kp_a  = 10'h004;
  localparam logic [region_lsb-1:0] reg_sp_b  = 10'h008;
  localparam logic [region_lsb-1:0] reg_kp_b  = 10'h00c;
  // DAC offsets
  localparam logic [region_lsb-1:0] reg_ofs_a = 10'h000;
  localparam logic [region_lsb-1:0] reg_ofs_b = 10'h004;

  localparam logic [31:0] design_id = 32'h5250_0001;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic signed [smp_w-1:0] sample_t;
  typedef logic        [smp_w-1:0] dac_code_t;  // Offset binary, negative slope

  typedef struct packed {
    logic [adc_pin_w-1:0] a;
    logic [adc_pin_w-1:0] b;
  } adc_pins_t;

  typedef struct packed {
    sample_t a;
    sample_t b;
  } smp_pair_t;

  typedef struct packed {
    logic [apb_aw-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [31:0]       pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

/* hw/rp_top.sv */
// Top level of the fast analog path, APB decoder, register slaves and signal chain
`timescale 1ns/1ps
`default_nettype none

module rp_top (
  input  wire                    adc_clk,
  input  wire                    rst_n_i,
  input  wire rp_pkg::apb_req_t  apb_req_i,
  output rp_pkg::apb_rsp_t       apb_rsp_o,
  input  wire rp_pkg::adc_pins_t adc_dat_i,    // Raw ADC pins
  output rp_pkg::dac_code_t      dac_a_o,
  output rp_pkg::dac_code_t      dac_b_o,
  output logic [7:0]             led_o
);

  import rp_pkg::*;

  apb_req_t  s_req [n_slv];   // Per-region requests
  apb_rsp_t  s_rsp [n_slv];
  smp_pair_t adc_smp;         // Pins after input register
  smp_pair_t pid_smp;         // Controller output
  smp_pair_t dac_smp;         // Saturated output samples
  logic      digital_loop;

  ////////////////////////////////////////////////////////////
  // Register bus
  ////////////////////////////////////////////////////////////

  apb_region_decoder u_dec (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .m_req_i (apb_req_i),
    .m_rsp_o (apb_rsp_o),
    .s_req_o (s_req),
    .s_rsp_i (s_rsp)
  );

  hk_regs u_hk (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .req_i          (s_req[rgn_hk]),
    .rsp_o          (s_rsp[rgn_hk]),
    .adc_smp_i      (adc_smp),       // Readback
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  ////////////////////////////////////////////////////////////
  // Signal chain, pins to DAC in 4 cycles
  ////////////////////////////////////////////////////////////

  adc_frontend u_adc (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_i      (adc_dat_i),
    .digital_loop_i (digital_loop),
    .dac_smp_i      (dac_smp),
    .adc_smp_o      (adc_smp)
  );

  p_ctrl u_pid (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .req_i     (s_req[rgn_pid]),
    .rsp_o     (s_rsp[rgn_pid]),
    .adc_smp_i (adc_smp),
    .pid_smp_o (pid_smp)
  );

  dac_backend u_dac (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .req_i     (s_req[rgn_dac]),
    .rsp_o     (s_rsp[rgn_dac]),
    .pid_smp_i (pid_smp),
    .dac_smp_o (dac_smp),
    .dac_a_o   (dac_a_o),
    .dac_b_o   (dac_b_o)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds and runs the testbench with Verilator, the exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rp_tb -f filelist.f \
  -Mdir obj_dir -o rp_sim \
  && ./obj_dir/rp_sim \
  || exit 1

/* verification/rp_props.sv */
// Concurrent checks on the APB handshake and the DAC outputs of the top level
`timescale 1ns/1ps
`default_nettype none

module rp_props (
  input wire                    adc_clk,
  input wire                    rst_n_i,
  input wire rp_pkg::apb_req_t  apb_req_i,
  input wire rp_pkg::apb_rsp_t  apb_rsp_i,
  input wire rp_pkg::dac_code_t dac_a_i,
  input wire rp_pkg::dac_code_t dac_b_i
);

  ////////////////////////////////////////////////////////////
  // APB response
  ////////////////////////////////////////////////////////////

  a_err_with_ready: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    apb_rsp_i.pslverr |-> apb_rsp_i.pready
  ) else $error("pslverr high without pready");

  // Zero wait states, pready marks the access phase only
  a_ready_in_access: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    apb_rsp_i.pready == (apb_req_i.psel && apb_req_i.penable)
  ) else $error("pready does not match the access phase");

  a_dac_known: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    !$isunknown({dac_a_i, dac_b_i})
  ) else $error("DAC output holds an unknown value");

endmodule

bind rp_top rp_props u_props (
  .adc_clk   (adc_clk),
  .rst_n_i   (rst_n_i),
  .apb_req_i (apb_req_i),
  .apb_rsp_i (apb_rsp_o),
  .dac_a_i   (dac_a_o),
  .dac_b_i   (dac_b_o)
);

`default_nettype wire

/* verification/rp_tb.sv */
// Testbench of the fast analog path with APB register checks and a table of signal cases
`timescale 1ns/1ps
`default_nettype none

module rp_tb;

  import rp_pkg::*;

  localparam int n_rows   = 14;
  localparam int clk_half = 4;        // 8 ns period

  // One row of stimulus with its expected results
  typedef struct {
    logic [adc_pin_w-1:0] pin_a;
    logic [adc_pin_w-1:0] pin_b;
    int                   sp_a;
    int                   sp_b;
    int                   kp_a;
    int                   kp_b;
    int                   ofs_a;
    int                   ofs_b;
    logic                 loop;
    dac_code_t            exp_code_a;
    dac_code_t            exp_code_b;
    sample_t              exp_smp_a;
    sample_t              exp_smp_b;
  } case_t;

  logic        adc_clk;
  logic        rst_n_i;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  adc_pins_t   adc_dat;
  dac_code_t   dac_a;
  dac_code_t   dac_b;
  logic [7:0]  led;
  case_t       cases [n_rows];
  integer      seed;
  logic [31:0] rd;               // Last APB read data

  rp_top u_rp_top (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp),
    .adc_dat_i (adc_dat),
    .dac_a_o   (dac_a),
    .dac_b_o   (dac_b),
    .led_o     (led)
  );

  initial begin
    adc_clk = 1'b0;
    forever #clk_half adc_clk = ~adc_clk;
  end

  // Watchdog budget covers every row plus the register tests
  initial begin
    repeat (n_rows * 200 + 2000) @(posedge adc_clk);
    stop_run("Watchdog expired before all cases finished");
  end

  ////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "Run stopped at %0t", $time);
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_code(input string name, input dac_code_t got, input dac_code_t exp);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_smp(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model of the signal path
  ////////////////////////////////////////////////////////////

  // Take pin bits 15:2 and flip all but the MSB before reading as signed
  function automatic int pin_value(input logic [adc_pin_w-1:0] pin);
    int v;
    v = {18'd0, pin[15:2]} ^ 32'h0000_1fff;
    if (v > 8191) begin
      v = v - 16384;
    end
    return v;
  endfunction

  function automatic int clamp_smp(input int v);
    if (v > 8191) begin
      return 8191;
    end
    if (v < -8192) begin
      return -8192;
    end
    return v;
  endfunction

  // Error times gain then floor divide by 256 and clamp
  function automatic int ref_ctrl(input int sp, input int smp, input int kp);
    int prod;
    prod = (sp - smp) * kp;
    return clamp_smp(prod >>> kp_shift);
  endfunction

  function automatic dac_code_t ref_code(input int s);
    return dac_code_t'(s) ^ 14'h1fff;     // Negative slope code
  endfunction

  // Sample value as a 32-bit two's complement word
  function automatic logic [31:0] sext(input sample_t s);
    int v;
    v = s;
    return v;
  endfunction

  function automatic logic [adc_pin_w-1:0] rnd_pin();
    return adc_pin_w'($random(seed));
  endfunction

  task automatic set_case(input int i, input logic [adc_pin_w-1:0] pa, pb,
                          input int spa, spb, kpa, kpb, oa, ob, input logic lp);
    int sa;
    int sb;
    sa = lp ? oa : pin_value(pa);   // Loopback with gain 0 settles on the offset
    sb = lp ? ob : pin_value(pb);
    cases[i].pin_a      = pa;
    cases[i].pin_b      = pb;
    cases[i].sp_a       = spa;
    cases[i].sp_b       = spb;
    cases[i].kp_a       = kpa;
    cases[i].kp_b       = kpb;
    cases[i].ofs_a      = oa;
    cases[i].ofs_b      = ob;
    cases[i].loop       = lp;
    cases[i].exp_smp_a  = sample_t'(sa);
    cases[i].exp_smp_b  = sample_t'(sb);
    cases[i].exp_code_a = ref_code(clamp_smp(ref_ctrl(spa, sa, kpa) + oa));
    cases[i].exp_code_b = ref_code(clamp_smp(ref_ctrl(spb, sb, kpb) + ob));
  endtask

  task automatic fill_table();
    set_case(0,  16'h0000, 16'hfffc, 0, 0, 0, 0, 0, 0, 1'b0);           // Pin extremes
    set_case(1,  16'h8000, 16'h7ffc, 0, 0, 0, 0, 0, 0, 1'b0);           // Around zero
    set_case(2,  rnd_pin(), rnd_pin(), 0, 0, 0, 0, 0, 0, 1'b0);
    set_case(3,  rnd_pin(), rnd_pin(), 0, 0, 0, 0, 0, 0, 1'b0);
    set_case(4,  rnd_pin(), rnd_pin(), 0, 0, 0, 0, 1000, -1000, 1'b0);  // Offsets only
    set_case(5,  16'h1234, 16'hab00, 0, 0, 0, 0, 8191, -8192, 1'b0);
    set_case(6,  16'h7ffc, 16'h8000, 100, -300, 256, 128, 0, 0, 1'b0);  // Gain 1.0 and 0.5
    set_case(7,  16'hfffc, 16'h0000, 8191, -8192, 2047, 2047, 0, 0, 1'b0);
    set_case(8,  16'hfffc, 16'h0000, 8191, -8192, 2047, 2047, 100, -100, 1'b0);
    set_case(9,  16'h7000, rnd_pin(), 0, 50, -512, -2048, 7000, -3000, 1'b0);
    set_case(10, rnd_pin(), rnd_pin(), 1234, -2345, 300, -77, 55, -66, 1'b0);
    set_case(11, rnd_pin(), rnd_pin(), 0, 0, 0, 0, 1500, -2500, 1'b1);  // Loopback
    set_case(12, rnd_pin(), rnd_pin(), 0, 0, 0, 0, -4000, 333, 1'b1);   // New offset
    set_case(13, rnd_pin(), rnd_pin(), 0, 0, 0, 0, 0, 0, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // APB master
  ////////////////////////////////////////////////////////////

  task automatic drive_setup(input logic [apb_aw-1:0] addr, input logic wr,
                             input logic [31:0] data);
    @(posedge adc_clk);
    #1;
    apb_req.paddr   = addr;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.pwdata  = data;
  endtask

  // Returns on the falling edge of the access phase where the response is stable
  task automatic drive_access();
    @(posedge adc_clk);
    #1;
    apb_req.penable = 1'b1;
    @(negedge adc_clk);
    check_flag("pready", apb_rsp.pready, 1'b1);
    check_flag("pslverr", apb_rsp.pslverr, apb_req.paddr[apb_aw-1:region_lsb] == 2'd3);
  endtask

  task automatic drive_idle();
    @(posedge adc_clk);                   // Write lands on this edge
    #1;
    apb_req = '0;
  endtask

  task automatic apb_write(input logic [apb_aw-1:0] addr, input logic [31:0] data);
    drive_setup(addr, 1'b1, data);
    drive_access();
    drive_idle();
  endtask

  task automatic apb_read(input logic [apb_aw-1:0] addr, output logic [31:0] data);
    drive_setup(addr, 1'b0, 32'd0);
    drive_access();
    data = apb_rsp.prdata;
    drive_idle();
  endtask

  task automatic write_read_back(input logic [apb_aw-1:0] addr, input logic [31:0] data);
    logic [31:0] got;
    apb_write(addr, data);
    apb_read(addr, got);
    check_word($sformatf("register %h", addr), got, data);
  endtask

  ////////////////////////////////////////////////////////////
  // Program one table row and check it after settling
  ////////////////////////////////////////////////////////////

  task automatic run_case(input int i);
    logic [31:0] word;
    @(posedge adc_clk);
    #1;
    adc_dat.a = cases[i].pin_a;
    adc_dat.b = cases[i].pin_b;
    apb_write({rgn_hk, reg_ctrl}, {31'd0, cases[i].loop});
    apb_write({rgn_pid, reg_sp_a}, cases[i].sp_a);
    apb_write({rgn_pid, reg_kp_a}, cases[i].kp_a);
    apb_write({rgn_pid, reg_sp_b}, cases[i].sp_b);
    apb_write({rgn_pid, reg_kp_b}, cases[i].kp_b);
    apb_write({rgn_dac, reg_ofs_a}, cases[i].ofs_a);
    apb_write({rgn_dac, reg_ofs_b}, cases[i].ofs_b);
    repeat (8) @(posedge adc_clk);       // Path fully settled
    @(negedge adc_clk);
    check_code($sformatf("dac_a_o row %0d", i), dac_a, cases[i].exp_code_a);
    check_code($sformatf("dac_b_o row %0d", i), dac_b, cases[i].exp_code_b);
    apb_read({rgn_hk, reg_adc_a}, word);
    check_smp($sformatf("reg_adc_a row %0d", i), word[smp_w-1:0], cases[i].exp_smp_a);
    check_word($sformatf("reg_adc_a row %0d", i), word, sext(cases[i].exp_smp_a));
    apb_read({rgn_hk, reg_adc_b}, word);
    check_smp($sformatf("reg_adc_b row %0d", i), word[smp_w-1:0], cases[i].exp_smp_b);
    check_word($sformatf("reg_adc_b row %0d", i), word, sext(cases[i].exp_smp_b));
  endtask

  initial begin
    seed    = 32'ha123eea6;
    rst_n_i = 1'b0;
    apb_req = '0;
    adc_dat = '0;
    fill_table();
    repeat (3) @(posedge adc_clk);
    #1;
    rst_n_i = 1'b1;

    // Reset state
    @(negedge adc_clk);
    check_code("dac_a_o", dac_a, 14'h1fff);
    check_code("dac_b_o", dac_b, 14'h1fff);
    check_word("led_o", {24'd0, led}, 32'd0);
    apb_read({rgn_hk, reg_id}, rd);
    check_word("reg_id", rd, design_id);

    // Signed registers read back sign extended
    write_read_back({rgn_hk, reg_ctrl}, 32'h0000_0001);
    write_read_back({rgn_hk, reg_led}, 32'h0000_00a5);
    write_read_back({rgn_pid, reg_sp_a}, -1234);
    write_read_back({rgn_pid, reg_kp_a}, -5);
    write_read_back({rgn_pid, reg_sp_b}, 4321);
    write_read_back({rgn_pid, reg_kp_b}, 2047);
    write_read_back({rgn_dac, reg_ofs_a}, -8192);
    write_read_back({rgn_dac, reg_ofs_b}, 8191);
    apb_write({rgn_hk, reg_ctrl}, 32'd0);
    apb_read({rgn_hk, 10'h3fc}, rd);     // Unknown hk offset
    check_word("hk unknown offset", rd, 32'd0);

    // Unmapped region 3
    apb_read(12'hc00, rd);
    check_word("region 3 prdata", rd, 32'd0);
    apb_write(12'hc04, 32'hdead_beef);

    // LED changes on the edge that closes the access phase
    drive_setup({rgn_hk, reg_led}, 1'b1, 32'h0000_003c);
    drive_access();
    check_word("led_o in access phase", {24'd0, led}, 32'h0000_00a5);
    drive_idle();
    check_word("led_o after access edge", {24'd0, led}, 32'h0000_003c);

    for (int i = 0; i < n_rows; i++) begin
      run_case(i);
    end

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire
